//--- Makefile
# Verilator flow for the fx1 fixed-point pipe

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module fx1_tb

sim:
	verilator --binary --timing -j 0 -f compile.f --top-module fx1_tb -o fx1_sim
	@out="$$(./obj_dir/fx1_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

//--- compile.f
+incdir+tests
source/fx1_pkg.sv
source/fx1_decode.sv
source/fx1_saturate.sv
source/fx1_compare.sv
source/fx1_writeback_pipe.sv
source/fx1_hazard.sv
source/fx1_unit.sv
tests/fx1_tb.sv

//--- source/fx1_compare.sv
`timescale 1ns/1ps
`default_nettype none

module fx1_compare (
	input wire logic [fx1_pkg::fn_w-1:0] func,
	input wire logic [1:0] size,
	input wire fx1_pkg::quad_t a,
	input wire fx1_pkg::quad_t b,
	output fx1_pkg::quad_t mask
);
	import fx1_pkg::*;

	// choose the relation the function asks for
	function automatic logic pick(
		input logic [fn_w-1:0] f,
		input logic eq,
		input logic gt,
		input logic lgt
	);
		case (f)
			fn_ceq: return eq;
			fn_cgt: return gt;
			fn_clgt: return lgt;
			default: return 1'b0;
		endcase
	endfunction

	always_comb begin
		mask = '0;
		case (size)
			sz_byte: begin
				for (int i = 0; i < byte_lanes; i++) begin
					mask.b[i] = {byte_w{pick(func, a.b[i] == b.b[i],
						$signed(a.b[i]) > $signed(b.b[i]), a.b[i] > b.b[i])}};
				end
			end
			sz_half: begin
				for (int i = 0; i < half_lanes; i++) begin
					mask.h[i] = {half_w{pick(func, a.h[i] == b.h[i],
						$signed(a.h[i]) > $signed(b.h[i]), a.h[i] > b.h[i])}};
				end
			end
			default: begin
				// word view
				for (int i = 0; i < word_lanes; i++) begin
					mask.w[i] = {word_w{pick(func, a.w[i] == b.w[i],
						$signed(a.w[i]) > $signed(b.w[i]), a.w[i] > b.w[i])}};
				end
			end
		endcase
	end

endmodule

`default_nettype wire

//--- source/fx1_decode.sv
`timescale 1ns/1ps
`default_nettype none

module fx1_decode (
	input wire logic [fx1_pkg::fmt_w-1:0] format,
	input wire logic [fx1_pkg::op_w-1:0] op,
	input wire logic [fx1_pkg::imm_w-1:0] imm,
	input wire fx1_pkg::quad_t rb,
	input wire logic reg_write,
	output logic [fx1_pkg::fn_w-1:0] func,
	output logic [1:0] size,
	output fx1_pkg::quad_t opnd_b,
	output logic wr_en,
	output logic squash
);
	import fx1_pkg::*;

	// imm10 sign-extended to halfword and word lanes
	logic [half_w-1:0] imm10_h;
	logic [word_w-1:0] imm10_w;
	logic [half_w-1:0] imm16;

	assign imm10_h = {{(half_w - 10){imm[9]}}, imm[9:0]};
	assign imm10_w = {{(word_w - 10){imm[9]}}, imm[9:0]};
	assign imm16 = imm[half_w-1:0];

	always_comb begin
		func = fn_add;
		size = sz_word;
		squash = 1'b0;
		opnd_b = rb;
		case (format)
			fmt_rr: begin
				case (op)
					op_ah: {func, size} = {fn_add, sz_half};
					op_a: {func, size} = {fn_add, sz_word};
					op_sfh: {func, size} = {fn_sub, sz_half};
					op_sf: {func, size} = {fn_sub, sz_word};
					op_and: func = fn_and;
					op_or: func = fn_or;
					op_xor: func = fn_xor;
					op_nand: func = fn_nand;
					op_ceqb: {func, size} = {fn_ceq, sz_byte};
					op_ceqh: {func, size} = {fn_ceq, sz_half};
					op_ceq: {func, size} = {fn_ceq, sz_word};
					op_cgtb: {func, size} = {fn_cgt, sz_byte};
					op_cgth: {func, size} = {fn_cgt, sz_half};
					op_cgt: {func, size} = {fn_cgt, sz_word};
					op_clgtb: {func, size} = {fn_clgt, sz_byte};
					op_clgth: {func, size} = {fn_clgt, sz_half};
					op_clgt: {func, size} = {fn_clgt, sz_word};
					// nop turns into a bubble
					op_nop: squash = 1'b1;
					default: squash = 1'b1;
				endcase
			end
			fmt_ri10: begin
				// upper op bits must be zero for a short opcode
				if (op[op_w-1:ri10_w] != '0) begin
					squash = 1'b1;
				end
				case (op[ri10_w-1:0])
					op_ahi: {func, size} = {fn_add, sz_half};
					op_ai: {func, size} = {fn_add, sz_word};
					op_sfhi: {func, size} = {fn_sub, sz_half};
					op_sfi: {func, size} = {fn_sub, sz_word};
					op_andbi: {func, size} = {fn_and, sz_byte};
					op_andhi: {func, size} = {fn_and, sz_half};
					op_andi: {func, size} = {fn_and, sz_word};
					op_orbi: {func, size} = {fn_or, sz_byte};
					op_orhi: {func, size} = {fn_or, sz_half};
					op_ori: {func, size} = {fn_or, sz_word};
					op_xorbi: {func, size} = {fn_xor, sz_byte};
					op_xorhi: {func, size} = {fn_xor, sz_half};
					op_xori: {func, size} = {fn_xor, sz_word};
					op_ceqbi: {func, size} = {fn_ceq, sz_byte};
					op_ceqhi: {func, size} = {fn_ceq, sz_half};
					op_ceqi: {func, size} = {fn_ceq, sz_word};
					op_cgtbi: {func, size} = {fn_cgt, sz_byte};
					op_cgthi: {func, size} = {fn_cgt, sz_half};
					op_cgti: {func, size} = {fn_cgt, sz_word};
					op_clgtbi: {func, size} = {fn_clgt, sz_byte};
					op_clgthi: {func, size} = {fn_clgt, sz_half};
					op_clgti: {func, size} = {fn_clgt, sz_word};
					default: squash = 1'b1;
				endcase
				// immediate replicated into every lane of the chosen size
				case (size)
					sz_byte: for (int i = 0; i < byte_lanes; i++) opnd_b.b[i] = imm[byte_w-1:0];
					sz_half: for (int i = 0; i < half_lanes; i++) opnd_b.h[i] = imm10_h;
					default: for (int i = 0; i < word_lanes; i++) opnd_b.w[i] = imm10_w;
				endcase
			end
			fmt_ri16: begin
				func = fn_load;
				if (op[op_w-1:ri16_w] != '0) begin
					squash = 1'b1;
				end
				case (op[ri16_w-1:0])
					op_ilh: for (int i = 0; i < half_lanes; i++) opnd_b.h[i] = imm16;
					op_ilhu: for (int i = 0; i < word_lanes; i++) opnd_b.w[i] = {imm16, 16'h0000};
					op_iohl: begin
						func = fn_or_rt;
						for (int i = 0; i < word_lanes; i++) opnd_b.w[i] = {16'h0000, imm16};
					end
					default: squash = 1'b1;
				endcase
			end
			// format 6 and the rest are not executed here
			default: squash = 1'b1;
		endcase
	end

	// a bubble never writes
	assign wr_en = reg_write && !squash;

endmodule

`default_nettype wire

//--- source/fx1_hazard.sv
`timescale 1ns/1ps
`default_nettype none

module fx1_hazard (
	input wire logic reset,
	input wire logic [fx1_pkg::reg_addr_w-1:0] st0_addr,
	input wire logic st0_write,
	input wire logic [fx1_pkg::reg_addr_w-1:0] ra_odd_addr,
	input wire logic [fx1_pkg::reg_addr_w-1:0] rb_odd_addr,
	input wire logic [fx1_pkg::reg_addr_w-1:0] ra_even_addr,
	input wire logic [fx1_pkg::reg_addr_w-1:0] rb_even_addr,
	input wire logic [fx1_pkg::reg_addr_w-1:0] rc_even_addr,
	output logic stall_odd_raw,
	output logic stall_even_raw
);
	logic odd_hit;
	logic even_hit;

	// source of the next issue matches the pending destination
	assign odd_hit = (st0_addr == ra_odd_addr) || (st0_addr == rb_odd_addr);
	assign even_hit = (st0_addr == ra_even_addr) || (st0_addr == rb_even_addr)
		|| (st0_addr == rc_even_addr);

	// only a writing instruction can cause a hazard
	assign stall_odd_raw = !reset && st0_write && odd_hit;
	assign stall_even_raw = !reset && st0_write && even_hit;

endmodule

`default_nettype wire

//--- source/fx1_pkg.sv
`default_nettype none

package fx1_pkg;

	// datapath and instruction field widths
	localparam int quad_w = 128;
	localparam int reg_addr_w = 7;
	localparam int op_w = 11;
	localparam int imm_w = 18;
	localparam int fmt_w = 3;
	// significant opcode bits for the short formats
	localparam int ri10_w = 8;
	localparam int ri16_w = 9;

	// lane widths and lane counts per quadword
	localparam int byte_w = 8;
	localparam int half_w = 16;
	localparam int word_w = 32;
	localparam int byte_lanes = quad_w / byte_w;
	localparam int half_lanes = quad_w / half_w;
	localparam int word_lanes = quad_w / word_w;

	// instruction formats
	localparam logic [fmt_w-1:0] fmt_rr = 3'd0;
	localparam logic [fmt_w-1:0] fmt_ri10 = 3'd4;
	localparam logic [fmt_w-1:0] fmt_ri16 = 3'd5;

	// rr opcodes, full 11 bits
	localparam logic [op_w-1:0] op_nop = 11'b00000000000;
	localparam logic [op_w-1:0] op_ah = 11'b00011001000;
	localparam logic [op_w-1:0] op_a = 11'b00011000000;
	localparam logic [op_w-1:0] op_sfh = 11'b00001001000;
	localparam logic [op_w-1:0] op_sf = 11'b00001000000;
	localparam logic [op_w-1:0] op_and = 11'b00011000001;
	localparam logic [op_w-1:0] op_or = 11'b00001000001;
	localparam logic [op_w-1:0] op_xor = 11'b01001000001;
	localparam logic [op_w-1:0] op_nand = 11'b00011001001;
	localparam logic [op_w-1:0] op_ceqb = 11'b01111010000;
	localparam logic [op_w-1:0] op_ceqh = 11'b01111001000;
	localparam logic [op_w-1:0] op_ceq = 11'b01111000000;
	localparam logic [op_w-1:0] op_cgtb = 11'b01001010000;
	localparam logic [op_w-1:0] op_cgth = 11'b01001001000;
	localparam logic [op_w-1:0] op_cgt = 11'b01001000000;
	localparam logic [op_w-1:0] op_clgtb = 11'b01011010000;
	localparam logic [op_w-1:0] op_clgth = 11'b01011001000;
	localparam logic [op_w-1:0] op_clgt = 11'b01011000000;

	// ri10 opcodes, right-aligned in the op field
	localparam logic [ri10_w-1:0] op_ahi = 8'b00011101;
	localparam logic [ri10_w-1:0] op_ai = 8'b00011100;
	localparam logic [ri10_w-1:0] op_sfhi = 8'b00001101;
	localparam logic [ri10_w-1:0] op_sfi = 8'b00001100;
	localparam logic [ri10_w-1:0] op_andbi = 8'b00010110;
	localparam logic [ri10_w-1:0] op_andhi = 8'b00010101;
	localparam logic [ri10_w-1:0] op_andi = 8'b00010100;
	localparam logic [ri10_w-1:0] op_orbi = 8'b00000110;
	localparam logic [ri10_w-1:0] op_orhi = 8'b00000101;
	localparam logic [ri10_w-1:0] op_ori = 8'b00000100;
	localparam logic [ri10_w-1:0] op_xorbi = 8'b01000110;
	localparam logic [ri10_w-1:0] op_xorhi = 8'b01000101;
	localparam logic [ri10_w-1:0] op_xori = 8'b01000100;
	localparam logic [ri10_w-1:0] op_ceqbi = 8'b01111110;
	localparam logic [ri10_w-1:0] op_ceqhi = 8'b01111101;
	localparam logic [ri10_w-1:0] op_ceqi = 8'b01111100;
	localparam logic [ri10_w-1:0] op_cgtbi = 8'b01001110;
	localparam logic [ri10_w-1:0] op_cgthi = 8'b01001101;
	localparam logic [ri10_w-1:0] op_cgti = 8'b01001100;
	localparam logic [ri10_w-1:0] op_clgtbi = 8'b01011110;
	localparam logic [ri10_w-1:0] op_clgthi = 8'b01011101;
	localparam logic [ri10_w-1:0] op_clgti = 8'b01011100;

	// ri16 immediate loads
	localparam logic [ri16_w-1:0] op_ilh = 9'b010000011;
	localparam logic [ri16_w-1:0] op_ilhu = 9'b010000010;
	localparam logic [ri16_w-1:0] op_iohl = 9'b011000001;

	// execution functions
	localparam int fn_w = 4;
	localparam logic [fn_w-1:0] fn_add = 4'd0;
	localparam logic [fn_w-1:0] fn_sub = 4'd1;
	localparam logic [fn_w-1:0] fn_and = 4'd2;
	localparam logic [fn_w-1:0] fn_or = 4'd3;
	localparam logic [fn_w-1:0] fn_xor = 4'd4;
	localparam logic [fn_w-1:0] fn_nand = 4'd5;
	localparam logic [fn_w-1:0] fn_ceq = 4'd6;
	localparam logic [fn_w-1:0] fn_cgt = 4'd7;
	localparam logic [fn_w-1:0] fn_clgt = 4'd8;
	// result is operand b as decoded
	localparam logic [fn_w-1:0] fn_load = 4'd9;
	// result is old rt value or operand b
	localparam logic [fn_w-1:0] fn_or_rt = 4'd10;

	// lane size codes
	localparam logic [1:0] sz_byte = 2'd0;
	localparam logic [1:0] sz_half = 2'd1;
	localparam logic [1:0] sz_word = 2'd2;

	// one quadword, three lane views, lane 0 in the top bits
	typedef union packed {
		logic [0:byte_lanes-1][byte_w-1:0] b;
		logic [0:half_lanes-1][half_w-1:0] h;
		logic [0:word_lanes-1][word_w-1:0] w;
	} quad_t;

	// signed clamp limits
	localparam logic [half_w-1:0] half_max = {1'b0, {(half_w - 1){1'b1}}};
	localparam logic [half_w-1:0] half_min = {1'b1, {(half_w - 1){1'b0}}};
	localparam logic [word_w-1:0] word_max = {1'b0, {(word_w - 1){1'b1}}};
	localparam logic [word_w-1:0] word_min = {1'b1, {(word_w - 1){1'b0}}};

endpackage

`default_nettype wire

//--- source/fx1_saturate.sv
`timescale 1ns/1ps
`default_nettype none

module fx1_saturate (
	input wire logic [fx1_pkg::fn_w-1:0] func,
	input wire logic [1:0] size,
	input wire fx1_pkg::quad_t a,
	input wire fx1_pkg::quad_t b,
	output fx1_pkg::quad_t sum
);
	import fx1_pkg::*;

	// one guard bit above each lane
	logic [half_w:0] raw_h;
	logic [word_w:0] raw_w;
	logic [half_w:0] a_h;
	logic [half_w:0] b_h;
	logic [word_w:0] a_w;
	logic [word_w:0] b_w;

	always_comb begin
		sum = '0;
		raw_h = '0;
		raw_w = '0;
		a_h = '0;
		b_h = '0;
		a_w = '0;
		b_w = '0;
		if (size == sz_half) begin
			for (int i = 0; i < half_lanes; i++) begin
				a_h = {a.h[i][half_w-1], a.h[i]};
				b_h = {b.h[i][half_w-1], b.h[i]};
				// subtract-from is b minus a
				raw_h = (func == fn_sub) ? b_h - a_h : a_h + b_h;
				// guard and sign differ only on overflow
				if (raw_h[half_w] != raw_h[half_w-1]) begin
					sum.h[i] = raw_h[half_w] ? half_min : half_max;
				end else begin
					sum.h[i] = raw_h[half_w-1:0];
				end
			end
		end else begin
			// word lanes, same clamp with the wider limits
			for (int i = 0; i < word_lanes; i++) begin
				a_w = {a.w[i][word_w-1], a.w[i]};
				b_w = {b.w[i][word_w-1], b.w[i]};
				raw_w = (func == fn_sub) ? b_w - a_w : a_w + b_w;
				if (raw_w[word_w] != raw_w[word_w-1]) begin
					sum.w[i] = raw_w[word_w] ? word_min : word_max;
				end else begin
					sum.w[i] = raw_w[word_w-1:0];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- source/fx1_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fx1_unit #(
	parameter int wb_depth = 2
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic [fx1_pkg::fmt_w-1:0] format,
	input wire logic [fx1_pkg::op_w-1:0] op,
	input wire logic [fx1_pkg::imm_w-1:0] imm,
	input wire logic [fx1_pkg::reg_addr_w-1:0] rt_addr,
	input wire logic reg_write,
	input wire logic branch_taken,
	input wire fx1_pkg::quad_t ra,
	input wire fx1_pkg::quad_t rb,
	input wire fx1_pkg::quad_t rt_st,
	input wire logic [fx1_pkg::reg_addr_w-1:0] ra_odd_addr,
	input wire logic [fx1_pkg::reg_addr_w-1:0] rb_odd_addr,
	input wire logic [fx1_pkg::reg_addr_w-1:0] ra_even_addr,
	input wire logic [fx1_pkg::reg_addr_w-1:0] rb_even_addr,
	input wire logic [fx1_pkg::reg_addr_w-1:0] rc_even_addr,
	output fx1_pkg::quad_t rt_wb,
	output logic [fx1_pkg::reg_addr_w-1:0] rt_addr_wb,
	output logic reg_write_wb,
	output logic stall_odd_raw,
	output logic stall_even_raw
);
	import fx1_pkg::*;

	// decoded controls
	logic [fn_w-1:0] func;
	logic [1:0] size;
	quad_t opnd_b;
	logic wr_en;
	logic squash;
	// lane results
	quad_t sum;
	quad_t mask;
	// pending destination for the RAW check
	logic [reg_addr_w-1:0] st0_addr;
	logic st0_write;

	fx1_decode decode_i (
		.format(format),
		.op(op),
		.imm(imm),
		.rb(rb),
		.reg_write(reg_write),
		.func(func),
		.size(size),
		.opnd_b(opnd_b),
		.wr_en(wr_en),
		.squash(squash)
	);

	fx1_saturate saturate_i (
		.func(func),
		.size(size),
		.a(ra),
		.b(opnd_b),
		.sum(sum)
	);

	fx1_compare compare_i (
		.func(func),
		.size(size),
		.a(ra),
		.b(opnd_b),
		.mask(mask)
	);

	fx1_writeback_pipe #(
		.wb_depth(wb_depth)
	) writeback_i (
		.clk(clk),
		.reset(reset),
		.func(func),
		.a(ra),
		.b(opnd_b),
		.rt_st(rt_st),
		.sum(sum),
		.mask(mask),
		.rt_addr(rt_addr),
		.wr_en(wr_en),
		.squash(squash),
		.branch_taken(branch_taken),
		.rt_wb(rt_wb),
		.rt_addr_wb(rt_addr_wb),
		.reg_write_wb(reg_write_wb),
		.st0_addr(st0_addr),
		.st0_write(st0_write)
	);

	fx1_hazard hazard_i (
		.reset(reset),
		.st0_addr(st0_addr),
		.st0_write(st0_write),
		.ra_odd_addr(ra_odd_addr),
		.rb_odd_addr(rb_odd_addr),
		.ra_even_addr(ra_even_addr),
		.rb_even_addr(rb_even_addr),
		.rc_even_addr(rc_even_addr),
		.stall_odd_raw(stall_odd_raw),
		.stall_even_raw(stall_even_raw)
	);

endmodule

`default_nettype wire

//--- source/fx1_writeback_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module fx1_writeback_pipe #(
	parameter int wb_depth = 2
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic [fx1_pkg::fn_w-1:0] func,
	input wire fx1_pkg::quad_t a,
	input wire fx1_pkg::quad_t b,
	input wire fx1_pkg::quad_t rt_st,
	input wire fx1_pkg::quad_t sum,
	input wire fx1_pkg::quad_t mask,
	input wire logic [fx1_pkg::reg_addr_w-1:0] rt_addr,
	input wire logic wr_en,
	input wire logic squash,
	input wire logic branch_taken,
	output fx1_pkg::quad_t rt_wb,
	output logic [fx1_pkg::reg_addr_w-1:0] rt_addr_wb,
	output logic reg_write_wb,
	output logic [fx1_pkg::reg_addr_w-1:0] st0_addr,
	output logic st0_write
);
	import fx1_pkg::*;

	quad_t result;
	logic kill;
	// entry 0 is written at the issue edge, the last one drives writeback
	quad_t data_q [0:wb_depth-1];
	logic [reg_addr_w-1:0] addr_q [0:wb_depth-1];
	logic write_q [0:wb_depth-1];

	// result select, logical ops evaluated on the whole quadword
	always_comb begin
		case (func)
			fn_add, fn_sub: result = sum;
			fn_and: result = a & b;
			fn_or: result = a | b;
			fn_xor: result = a ^ b;
			fn_nand: result = ~(a & b);
			fn_ceq, fn_cgt, fn_clgt: result = mask;
			fn_load: result = b;
			fn_or_rt: result = rt_st | b;
			default: result = '0;
		endcase
	end

	// bubbles and squashed slots carry nothing
	assign kill = squash || branch_taken;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < wb_depth; i++) begin
				data_q[i] <= '0;
				addr_q[i] <= '0;
				write_q[i] <= 1'b0;
			end
		end else begin
			data_q[0] <= kill ? '0 : result;
			addr_q[0] <= kill ? '0 : rt_addr;
			write_q[0] <= wr_en && !kill;
			for (int i = 1; i < wb_depth; i++) begin
				data_q[i] <= data_q[i-1];
				addr_q[i] <= addr_q[i-1];
				write_q[i] <= write_q[i-1];
			end
		end
	end

	assign rt_wb = data_q[wb_depth-1];
	assign rt_addr_wb = addr_q[wb_depth-1];
	assign reg_write_wb = write_q[wb_depth-1];
	// stage 0 for the RAW check
	assign st0_addr = addr_q[0];
	assign st0_write = write_q[0];

endmodule

`default_nettype wire

//--- tests/fx1_model.svh
`ifndef FX1_MODEL_SVH
`define FX1_MODEL_SVH

// instruction classes as the model sees them
localparam logic [3:0] cls_add = 4'd0;
localparam logic [3:0] cls_sub = 4'd1;
localparam logic [3:0] cls_and = 4'd2;
localparam logic [3:0] cls_or = 4'd3;
localparam logic [3:0] cls_xor = 4'd4;
localparam logic [3:0] cls_nand = 4'd5;
localparam logic [3:0] cls_ceq = 4'd6;
localparam logic [3:0] cls_cgt = 4'd7;
localparam logic [3:0] cls_clgt = 4'd8;
localparam logic [3:0] cls_ilh = 4'd9;
localparam logic [3:0] cls_ilhu = 4'd10;
localparam logic [3:0] cls_iohl = 4'd11;

// kinds 0..16 are RR, 17..38 RI10, 39..41 RI16
localparam int n_kinds = 42;
localparam logic [op_w-1:0] kind_op [0:n_kinds-1] = '{
	op_ah, op_a, op_sfh, op_sf, op_and, op_or, op_xor, op_nand,
	op_ceqb, op_ceqh, op_ceq, op_cgtb, op_cgth, op_cgt, op_clgtb, op_clgth, op_clgt,
	11'(op_ahi), 11'(op_ai), 11'(op_sfhi), 11'(op_sfi), 11'(op_andbi), 11'(op_andhi),
	11'(op_andi), 11'(op_orbi), 11'(op_orhi), 11'(op_ori), 11'(op_xorbi), 11'(op_xorhi),
	11'(op_xori), 11'(op_ceqbi), 11'(op_ceqhi), 11'(op_ceqi), 11'(op_cgtbi), 11'(op_cgthi),
	11'(op_cgti), 11'(op_clgtbi), 11'(op_clgthi), 11'(op_clgti),
	11'(op_ilh), 11'(op_ilhu), 11'(op_iohl)
};
// class and lane code, lane width is 8 << code (code 3 is the whole quadword)
localparam logic [5:0] kind_cls [0:n_kinds-1] = '{
	{cls_add, 2'd1}, {cls_add, 2'd2}, {cls_sub, 2'd1}, {cls_sub, 2'd2}, {cls_and, 2'd3},
	{cls_or, 2'd3}, {cls_xor, 2'd3}, {cls_nand, 2'd3}, {cls_ceq, 2'd0}, {cls_ceq, 2'd1},
	{cls_ceq, 2'd2}, {cls_cgt, 2'd0}, {cls_cgt, 2'd1}, {cls_cgt, 2'd2}, {cls_clgt, 2'd0},
	{cls_clgt, 2'd1}, {cls_clgt, 2'd2},
	{cls_add, 2'd1}, {cls_add, 2'd2}, {cls_sub, 2'd1}, {cls_sub, 2'd2}, {cls_and, 2'd0},
	{cls_and, 2'd1}, {cls_and, 2'd2}, {cls_or, 2'd0}, {cls_or, 2'd1}, {cls_or, 2'd2},
	{cls_xor, 2'd0}, {cls_xor, 2'd1}, {cls_xor, 2'd2}, {cls_ceq, 2'd0}, {cls_ceq, 2'd1},
	{cls_ceq, 2'd2}, {cls_cgt, 2'd0}, {cls_cgt, 2'd1}, {cls_cgt, 2'd2}, {cls_clgt, 2'd0},
	{cls_clgt, 2'd1}, {cls_clgt, 2'd2},
	{cls_ilh, 2'd0}, {cls_ilhu, 2'd0}, {cls_iohl, 2'd0}
};

function automatic logic [fmt_w-1:0] kind_format(input int k);
	if (k < 17) begin
		return fmt_rr;
	end
	if (k < 39) begin
		return fmt_ri10;
	end
	return fmt_ri16;
endfunction

// galois form, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// signed range of a lane of width lw
function automatic longint clamp_lane(input longint v, input int lw);
	longint hi;
	hi = (64'sd1 <<< (lw - 1)) - 64'sd1;
	if (v > hi) begin
		return hi;
	end
	if (v < -hi - 64'sd1) begin
		return -hi - 64'sd1;
	end
	return v;
endfunction

// expected result, lanes counted from bit 0 upwards
function automatic logic [127:0] model_result(input logic [5:0] cl, input logic is_imm,
		input logic [imm_w-1:0] imm, input logic [127:0] ra, input logic [127:0] rb,
		input logic [127:0] rt);
	logic [3:0] c;
	int lw;
	logic [31:0] ext;
	logic [127:0] b;
	logic [127:0] res;
	longint ua;
	longint ub;
	longint sa;
	longint sb;
	longint r;
	longint top;
	c = cl[5:2];
	lw = 8 << cl[1:0];
	// byte forms take imm[7:0], wider lanes the sign-extended imm[9:0]
	ext = (lw == 8) ? {24'd0, imm[7:0]} : {{22{imm[9]}}, imm[9:0]};
	b = rb;
	if (is_imm) begin
		for (int j = 0; j < 128; j++) begin
			b[j] = ext[j % lw];
		end
	end
	res = '0;
	case (c)
		cls_and: res = ra & b;
		cls_or: res = ra | b;
		cls_xor: res = ra ^ b;
		cls_nand: res = ~(ra & b);
		cls_ilh: begin
			for (int j = 0; j < 128; j++) begin
				res[j] = imm[j % 16];
			end
		end
		cls_ilhu: begin
			// immediate in the upper half of each word
			for (int j = 0; j < 128; j++) begin
				res[j] = (j % 32 >= 16) ? imm[j % 32 - 16] : 1'b0;
			end
		end
		cls_iohl: begin
			for (int j = 0; j < 128; j++) begin
				res[j] = rt[j] | ((j % 32 < 16) ? imm[j % 32] : 1'b0);
			end
		end
		default: begin
			top = 64'sd1 <<< lw;
			for (int i = 0; i < 128 / lw; i++) begin
				ua = '0;
				ub = '0;
				for (int j = 0; j < lw; j++) begin
					ua[j] = ra[i * lw + j];
					ub[j] = b[i * lw + j];
				end
				sa = ua[lw - 1] ? ua - top : ua;
				sb = ub[lw - 1] ? ub - top : ub;
				case (c)
					cls_add: r = clamp_lane(sa + sb, lw);
					// subtract-from takes ra away from b
					cls_sub: r = clamp_lane(sb - sa, lw);
					cls_ceq: r = (ua == ub) ? -64'sd1 : 64'sd0;
					cls_cgt: r = (sa > sb) ? -64'sd1 : 64'sd0;
					default: r = (ua > ub) ? -64'sd1 : 64'sd0;
				endcase
				for (int j = 0; j < lw; j++) begin
					res[i * lw + j] = r[j];
				end
			end
		end
	endcase
	return res;
endfunction

`endif

//--- tests/fx1_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fx1_tb;
	import fx1_pkg::*;

	`include "fx1_model.svh"

	localparam int n_inst = 2000;
	localparam int wb_depth = 2;
	// reset, issue and drain fit well inside the margin
	localparam int cycle_limit = n_inst + 20;

	logic clk = 1'b0;
	logic reset;
	logic [fmt_w-1:0] format;
	logic [op_w-1:0] op;
	logic [imm_w-1:0] imm;
	logic [reg_addr_w-1:0] rt_addr;
	logic reg_write;
	logic branch_taken;
	quad_t ra;
	quad_t rb;
	quad_t rt_st;
	logic [reg_addr_w-1:0] ra_odd_addr;
	logic [reg_addr_w-1:0] rb_odd_addr;
	logic [reg_addr_w-1:0] ra_even_addr;
	logic [reg_addr_w-1:0] rb_even_addr;
	logic [reg_addr_w-1:0] rc_even_addr;
	quad_t rt_wb;
	logic [reg_addr_w-1:0] rt_addr_wb;
	logic reg_write_wb;
	logic stall_odd_raw;
	logic stall_even_raw;

	logic [31:0] lfsr;
	int cycles = 0;
	// expected writeback entries in issue order
	quad_t exp_data [$];
	logic [reg_addr_w-1:0] exp_addr [$];
	logic exp_write [$];
	// instruction in stage 0 as the RAW check sees it
	logic prev_write;
	logic [reg_addr_w-1:0] prev_dest;

	fx1_unit #(.wb_depth(wb_depth)) dut_i (
		.clk(clk), .reset(reset), .format(format), .op(op), .imm(imm),
		.rt_addr(rt_addr), .reg_write(reg_write), .branch_taken(branch_taken),
		.ra(ra), .rb(rb), .rt_st(rt_st),
		.ra_odd_addr(ra_odd_addr), .rb_odd_addr(rb_odd_addr),
		.ra_even_addr(ra_even_addr), .rb_even_addr(rb_even_addr),
		.rc_even_addr(rc_even_addr),
		.rt_wb(rt_wb), .rt_addr_wb(rt_addr_wb), .reg_write_wb(reg_write_wb),
		.stall_odd_raw(stall_odd_raw), .stall_even_raw(stall_even_raw)
	);

	always #20 clk = ~clk;

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			stop_with_failure($sformatf("timeout, run still going after %0d cycles", cycles));
		end
	end

	task automatic check_quad(input string name, input quad_t expected, input quad_t actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("Mismatch %s: expected %h, actual %h",
				name, expected, actual));
		end
	endtask

	task automatic check_addr(input string name, input logic [reg_addr_w-1:0] expected,
			input logic [reg_addr_w-1:0] actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("Mismatch %s: expected %0d, actual %0d",
				name, expected, actual));
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("Mismatch %s: expected %b, actual %b",
				name, expected, actual));
		end
	endtask

	// one lfsr step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// few registers so RAW matches come often
	function automatic logic [reg_addr_w-1:0] random_addr();
		logic [31:0] v;
		v = take_bits(3);
		return v[reg_addr_w-1:0];
	endfunction

	// about one word lane in four pushed near a clamp limit
	function automatic quad_t random_quad();
		quad_t q;
		logic [3:0] low_bits;
		for (int i = 0; i < word_lanes; i++) begin
			q.w[i] = take_bits(32);
			if (take_bits(2) == 0) begin
				low_bits = 4'(take_bits(4));
				case (take_bits(2))
					0: q.w[i] = {28'h7ff_ffff, low_bits};
					1: q.w[i] = {28'h800_0000, low_bits};
					// two halfwords near their limits
					2: q.w[i] = {12'h7ff, low_bits, 12'h7ff, low_bits};
					default: q.w[i] = {12'h800, low_bits, 12'h800, low_bits};
				endcase
			end
		end
		return q;
	endfunction

	// draw, drive and queue the writeback of one issue slot
	task automatic issue_instruction(input logic idle, output logic will_write,
			output logic [reg_addr_w-1:0] dest);
		int kind;
		logic bubble;
		kind = idle ? n_kinds : int'(take_bits(6) % 48);
		format = fmt_rr;
		op = op_nop;
		imm = 18'(take_bits(18));
		rt_addr = random_addr();
		reg_write = (take_bits(2) != 0);
		branch_taken = 1'b0;
		ra = random_quad();
		rb = random_quad();
		rt_st = random_quad();
		ra_odd_addr = random_addr();
		rb_odd_addr = random_addr();
		ra_even_addr = random_addr();
		rb_even_addr = random_addr();
		rc_even_addr = random_addr();
		if (kind >= 46) begin
			// real instruction killed by a taken branch
			kind = int'(take_bits(6) % n_kinds);
			branch_taken = 1'b1;
		end
		if (kind < n_kinds) begin
			format = kind_format(kind);
			op = kind_op[kind];
		end else if (kind >= 44) begin
			// codes no decoder entry knows
			format = (kind == 44) ? fmt_rr : 3'd7;
			op = (kind == 44) ? 11'h7ff : 11'(take_bits(11));
		end
		// kinds 42 and 43 stay a nop
		bubble = branch_taken || kind >= n_kinds;
		if (bubble) begin
			exp_data.push_back('0);
			exp_addr.push_back('0);
			exp_write.push_back(1'b0);
		end else begin
			exp_data.push_back(model_result(kind_cls[kind], format == fmt_ri10, imm,
				ra, rb, rt_st));
			exp_addr.push_back(rt_addr);
			exp_write.push_back(reg_write);
		end
		will_write = !bubble && reg_write;
		dest = rt_addr;
	endtask

	initial begin
		logic will_write;
		logic [reg_addr_w-1:0] dest;
		lfsr = 32'd90814;
		reset = 1'b1;
		format = '0;
		op = '0;
		imm = '0;
		rt_addr = '0;
		reg_write = 1'b0;
		branch_taken = 1'b0;
		ra = '0;
		rb = '0;
		rt_st = '0;
		ra_odd_addr = '0;
		rb_odd_addr = '0;
		ra_even_addr = '0;
		rb_even_addr = '0;
		rc_even_addr = '0;
		prev_write = 1'b0;
		prev_dest = '0;
		// empty pipe until the first instruction arrives
		for (int i = 0; i < wb_depth; i++) begin
			exp_data.push_back('0);
			exp_addr.push_back('0);
			exp_write.push_back(1'b0);
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_quad("rt_wb in reset", '0, rt_wb);
		check_addr("rt_addr_wb in reset", '0, rt_addr_wb);
		check_bit("reg_write_wb in reset", 1'b0, reg_write_wb);
		check_bit("stall_odd_raw in reset", 1'b0, stall_odd_raw);
		check_bit("stall_even_raw in reset", 1'b0, stall_even_raw);
		reset = 1'b0;
		for (int n = 0; n < n_inst + wb_depth; n++) begin
			// entry issued wb_depth slots ago is at writeback
			check_quad($sformatf("rt_wb slot %0d", n), exp_data.pop_front(), rt_wb);
			check_addr($sformatf("rt_addr_wb slot %0d", n), exp_addr.pop_front(), rt_addr_wb);
			check_bit($sformatf("reg_write_wb slot %0d", n), exp_write.pop_front(),
				reg_write_wb);
			issue_instruction(n >= n_inst, will_write, dest);
			// stall outputs settle on the new source addresses
			#1;
			check_bit($sformatf("stall_odd_raw slot %0d", n), prev_write
				&& (prev_dest == ra_odd_addr || prev_dest == rb_odd_addr), stall_odd_raw);
			check_bit($sformatf("stall_even_raw slot %0d", n), prev_write
				&& (prev_dest == ra_even_addr || prev_dest == rb_even_addr
				|| prev_dest == rc_even_addr), stall_even_raw);
			prev_write = will_write;
			prev_dest = dest;
			@(negedge clk);
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
